// ==== rename_pkg.sv ====
package rename_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // machine sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int arch_regs  = 8;
    localparam int phys_regs  = 16;
    localparam int rob_depth  = 8;   // default depth, cpu passes it down
    localparam int rs_depth   = 4;
    localparam int data_width = 32;

    // physical registers left over once every arch reg has a mapping
    localparam int free_regs = phys_regs - arch_regs;

    ////////////////////////////////////////////////////////////////////////////
    // index and value types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [$clog2(arch_regs)-1:0] arch_idx_t;
    typedef logic [$clog2(phys_regs)-1:0] phys_idx_t;
    typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;
    typedef logic [data_width-1:0]        data_t;
    typedef logic [15:0]                  imm_t;

    // alu opcodes
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_li  = 3'd5     // sign-extended 16 bit immediate
    } alu_op_t;

endpackage

// ==== map_table.sv ====
`timescale 1ns/1ps

module map_table (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_en,
    input  rename_pkg::arch_idx_t dest,
    input  rename_pkg::arch_idx_t src1,
    input  rename_pkg::arch_idx_t src2,
    input  rename_pkg::phys_idx_t new_phys,
    output rename_pkg::phys_idx_t src1_phys,
    output rename_pkg::phys_idx_t src2_phys,
    output rename_pkg::phys_idx_t old_phys
);

    // speculative arch to phys map
    rename_pkg::phys_idx_t map_q [rename_pkg::arch_regs];

    // reads see the map before this cycle's write
    assign src1_phys = map_q[src1];
    assign src2_phys = map_q[src2];
    assign old_phys  = map_q[dest];   // freed when this instruction retires

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::arch_regs; i++) begin
                map_q[i] <= rename_pkg::phys_idx_t'(i);   // identity map
            end
        end else if (dispatch_en) begin
            map_q[dest] <= new_phys;
        end
    end

endmodule

// ==== free_list.sv ====
`timescale 1ns/1ps

module free_list (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  pop,
    input  logic                  push,
    input  rename_pkg::phys_idx_t push_phys,
    output rename_pkg::phys_idx_t head_phys,
    output logic                  empty
);

    localparam int depth = rename_pkg::free_regs;
    localparam int ptr_w = $clog2(depth);

    rename_pkg::phys_idx_t entries [depth];

    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [ptr_w:0]   count;

    assign head_phys = entries[head];
    assign empty     = (count == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            // registers above the arch range start out free
            for (int i = 0; i < depth; i++) begin
                entries[i] <= rename_pkg::phys_idx_t'(rename_pkg::arch_regs + i);
            end
            head  <= '0;
            tail  <= '0;   // full queue, tail wrapped onto head
            count <= (ptr_w + 1)'(depth);
        end else begin
            if (pop) begin
                head <= head + 1'b1;
            end
            if (push) begin
                entries[tail] <= push_phys;
                tail          <= tail + 1'b1;
            end
            // pop and push together leave the count alone
            if (pop && !push) begin
                count <= count - 1'b1;
            end else if (push && !pop) begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// ==== phys_regfile.sv ====
`timescale 1ns/1ps

module phys_regfile (
    input  logic                  clock,
    input  logic                  reset,
    input  rename_pkg::phys_idx_t rd1_phys,
    input  rename_pkg::phys_idx_t rd2_phys,
    input  logic                  alloc_en,
    input  rename_pkg::phys_idx_t alloc_phys,
    input  logic                  wr_en,
    input  rename_pkg::phys_idx_t wr_phys,
    input  rename_pkg::data_t     wr_data,
    output rename_pkg::data_t     rd1_data,
    output rename_pkg::data_t     rd2_data,
    output logic                  rd1_ready,
    output logic                  rd2_ready
);

    rename_pkg::data_t                 values [rename_pkg::phys_regs];
    logic [rename_pkg::phys_regs-1:0] ready;

    logic hit1;
    logic hit2;

    // bypass the value being broadcast this cycle
    assign hit1      = wr_en && (wr_phys == rd1_phys);
    assign hit2      = wr_en && (wr_phys == rd2_phys);
    assign rd1_data  = hit1 ? wr_data : values[rd1_phys];
    assign rd2_data  = hit2 ? wr_data : values[rd2_phys];
    assign rd1_ready = hit1 | ready[rd1_phys];
    assign rd2_ready = hit2 | ready[rd2_phys];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::phys_regs; i++) begin
                values[i] <= '0;
                ready[i]  <= (i < rename_pkg::arch_regs);   // only mapped regs valid
            end
        end else begin
            if (wr_en) begin
                values[wr_phys] <= wr_data;
                ready[wr_phys]  <= 1'b1;
            end
            if (alloc_en) begin
                ready[alloc_phys] <= 1'b0;   // new dest, pending result
            end
        end
    end

endmodule

// ==== rs.sv ====
`timescale 1ns/1ps

module rs #(
    parameter int rs_depth = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_en,
    input  rename_pkg::alu_op_t   op,
    input  rename_pkg::imm_t      imm,
    input  rename_pkg::phys_idx_t dest_phys,
    input  rename_pkg::rob_idx_t  tag,
    input  rename_pkg::phys_idx_t src1_phys,
    input  rename_pkg::phys_idx_t src2_phys,
    input  rename_pkg::data_t     src1_data,
    input  rename_pkg::data_t     src2_data,
    input  logic                  src1_ready,
    input  logic                  src2_ready,
    input  logic                  cdb_valid,
    input  rename_pkg::phys_idx_t cdb_phys,
    input  rename_pkg::data_t     cdb_data,
    output logic                  full,
    output logic                  issue_valid,
    output rename_pkg::alu_op_t   issue_op,
    output rename_pkg::data_t     issue_a,
    output rename_pkg::data_t     issue_b,
    output rename_pkg::imm_t      issue_imm,
    output rename_pkg::phys_idx_t issue_dest_phys,
    output rename_pkg::rob_idx_t  issue_tag
);

    localparam int idx_w = $clog2(rs_depth);

    ////////////////////////////////////////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////////////////////////////////////////

    logic [rs_depth-1:0]   valid;
    logic [rs_depth-1:0]   rdy1;
    logic [rs_depth-1:0]   rdy2;
    rename_pkg::alu_op_t   op_q   [rs_depth];
    rename_pkg::imm_t      imm_q  [rs_depth];
    rename_pkg::phys_idx_t dest_q [rs_depth];
    rename_pkg::rob_idx_t  tag_q  [rs_depth];
    rename_pkg::phys_idx_t phys1  [rs_depth];
    rename_pkg::phys_idx_t phys2  [rs_depth];
    rename_pkg::data_t     val1   [rs_depth];
    rename_pkg::data_t     val2   [rs_depth];

    logic [idx_w-1:0] alloc_idx;
    logic [idx_w-1:0] issue_idx;
    logic             is_li;

    assign full  = &valid;
    assign is_li = (op == rename_pkg::op_li);   // no register sources

    // lowest free slot and lowest ready slot, scanned downward
    always_comb begin
        alloc_idx   = '0;
        issue_idx   = '0;
        issue_valid = 1'b0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                alloc_idx = idx_w'(i);
            end
            if (valid[i] && rdy1[i] && rdy2[i]) begin
                issue_idx   = idx_w'(i);
                issue_valid = 1'b1;
            end
        end
    end

    assign issue_op        = op_q[issue_idx];
    assign issue_a         = val1[issue_idx];
    assign issue_b         = val2[issue_idx];
    assign issue_imm       = imm_q[issue_idx];
    assign issue_dest_phys = dest_q[issue_idx];
    assign issue_tag       = tag_q[issue_idx];

    ////////////////////////////////////////////////////////////////////////////
    // control: valid and ready bits
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            rdy1  <= '0;
            rdy2  <= '0;
        end else begin
            for (int i = 0; i < rs_depth; i++) begin
                if (cdb_valid && valid[i] && !rdy1[i] && phys1[i] == cdb_phys) begin
                    rdy1[i] <= 1'b1;   // wakeup
                end
                if (cdb_valid && valid[i] && !rdy2[i] && phys2[i] == cdb_phys) begin
                    rdy2[i] <= 1'b1;
                end
            end
            if (issue_valid) begin
                valid[issue_idx] <= 1'b0;   // freed as it leaves
            end
            if (dispatch_en) begin
                valid[alloc_idx] <= 1'b1;
                rdy1[alloc_idx]  <= src1_ready | is_li;
                rdy2[alloc_idx]  <= src2_ready | is_li;
            end
        end
    end

    // payload, captured at dispatch or from the broadcast
    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (cdb_valid && !rdy1[i] && phys1[i] == cdb_phys) begin
                val1[i] <= cdb_data;
            end
            if (cdb_valid && !rdy2[i] && phys2[i] == cdb_phys) begin
                val2[i] <= cdb_data;
            end
        end
        if (dispatch_en) begin
            op_q[alloc_idx]   <= op;
            imm_q[alloc_idx]  <= imm;
            dest_q[alloc_idx] <= dest_phys;
            tag_q[alloc_idx]  <= tag;
            phys1[alloc_idx]  <= src1_phys;
            phys2[alloc_idx]  <= src2_phys;
            val1[alloc_idx]   <= src1_data;
            val2[alloc_idx]   <= src2_data;
        end
    end

endmodule

// ==== alu_fu.sv ====
`timescale 1ns/1ps

module alu_fu (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  rename_pkg::alu_op_t   issue_op,
    input  rename_pkg::data_t     issue_a,
    input  rename_pkg::data_t     issue_b,
    input  rename_pkg::imm_t      issue_imm,
    input  rename_pkg::phys_idx_t issue_dest_phys,
    input  rename_pkg::rob_idx_t  issue_tag,
    output logic                  cdb_valid,
    output rename_pkg::phys_idx_t cdb_phys,
    output rename_pkg::rob_idx_t  cdb_tag,
    output rename_pkg::data_t     cdb_data
);

    rename_pkg::data_t result;

    always_comb begin
        case (issue_op)
            rename_pkg::op_add: result = issue_a + issue_b;
            rename_pkg::op_sub: result = issue_a - issue_b;
            rename_pkg::op_and: result = issue_a & issue_b;
            rename_pkg::op_or:  result = issue_a | issue_b;
            rename_pkg::op_xor: result = issue_a ^ issue_b;
            rename_pkg::op_li:
                result = {{(rename_pkg::data_width - 16){issue_imm[15]}}, issue_imm};
            default:            result = '0;
        endcase
    end

    // one cycle, straight onto the broadcast bus
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        cdb_phys <= issue_dest_phys;
        cdb_tag  <= issue_tag;
        cdb_data <= result;
    end

endmodule

// ==== rob.sv ====
`timescale 1ns/1ps

module rob #(
    parameter int rob_depth = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_en,
    input  rename_pkg::arch_idx_t dest,
    input  rename_pkg::phys_idx_t old_phys,
    input  logic                  cdb_valid,
    input  rename_pkg::rob_idx_t  cdb_tag,
    input  rename_pkg::data_t     cdb_data,
    output rename_pkg::rob_idx_t  alloc_tag,
    output logic                  full,
    output logic                  retire_valid,
    output rename_pkg::arch_idx_t retire_dest,
    output rename_pkg::data_t     retire_data,
    output rename_pkg::phys_idx_t retire_old_phys
);

    localparam int ptr_w = $clog2(rob_depth);

    rename_pkg::arch_idx_t dest_q [rob_depth];
    rename_pkg::phys_idx_t old_q  [rob_depth];
    rename_pkg::data_t     data_q [rob_depth];
    logic [rob_depth-1:0]  done;

    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [ptr_w:0]   count;
    logic [ptr_w-1:0] cdb_slot;
    logic             retire_go;

    assign alloc_tag = rename_pkg::rob_idx_t'(tail);   // tag is the slot number
    assign full      = (count == (ptr_w + 1)'(rob_depth));
    assign cdb_slot  = cdb_tag[ptr_w-1:0];
    assign retire_go = (count != '0) && done[head];   // oldest one finished

    ////////////////////////////////////////////////////////////////////////////
    // pointers and completion
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done         <= '0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= retire_go;
            if (dispatch_en) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb_valid) begin
                done[cdb_slot] <= 1'b1;
            end
            if (retire_go) begin
                head <= head + 1'b1;
            end
            if (dispatch_en && !retire_go) begin
                count <= count + 1'b1;
            end else if (retire_go && !dispatch_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // entry payload and the registered retire port
    always_ff @(posedge clock) begin
        if (dispatch_en) begin
            dest_q[tail] <= dest;
            old_q[tail]  <= old_phys;
        end
        if (cdb_valid) begin
            data_q[cdb_slot] <= cdb_data;
        end
        if (retire_go) begin
            retire_dest     <= dest_q[head];
            retire_data     <= data_q[head];
            retire_old_phys <= old_q[head];
        end
    end

endmodule

// ==== cpu.sv ====
`timescale 1ns/1ps

module cpu (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    input  rename_pkg::alu_op_t   in_op,
    input  rename_pkg::arch_idx_t in_dest,
    input  rename_pkg::arch_idx_t in_src1,
    input  rename_pkg::arch_idx_t in_src2,
    input  rename_pkg::imm_t      in_imm,
    output logic                  dispatch_open,
    output logic                  commit_valid,
    output rename_pkg::arch_idx_t commit_dest,
    output rename_pkg::data_t     commit_data
);

    ////////////////////////////////////////////////////////////////////////////
    // wires
    ////////////////////////////////////////////////////////////////////////////

    logic                  dispatch_en;
    rename_pkg::phys_idx_t src1_phys, src2_phys, old_phys, new_phys;
    logic                  fl_empty;
    rename_pkg::data_t     src1_data, src2_data;
    logic                  src1_ready, src2_ready;
    logic                  rs_full, rob_full;
    rename_pkg::rob_idx_t  alloc_tag;

    // issue to alu
    logic                  issue_valid;
    rename_pkg::alu_op_t   issue_op;
    rename_pkg::data_t     issue_a, issue_b;
    rename_pkg::imm_t      issue_imm;
    rename_pkg::phys_idx_t issue_dest_phys;
    rename_pkg::rob_idx_t  issue_tag;

    // broadcast
    logic                  cdb_valid;
    rename_pkg::phys_idx_t cdb_phys;
    rename_pkg::rob_idx_t  cdb_tag;
    rename_pkg::data_t     cdb_data;

    logic                  retire_valid;
    rename_pkg::phys_idx_t retire_old_phys;

    // accept only with a free reg, a rob slot and an rs slot
    assign dispatch_open = !fl_empty && !rob_full && !rs_full;
    assign dispatch_en   = in_valid && dispatch_open;
    assign commit_valid  = retire_valid;

    ////////////////////////////////////////////////////////////////////////////
    // rename, schedule, execute, retire
    ////////////////////////////////////////////////////////////////////////////

    map_table map_i (
        .clock(clock), .reset(reset), .dispatch_en(dispatch_en),
        .dest(in_dest), .src1(in_src1), .src2(in_src2), .new_phys(new_phys),
        .src1_phys(src1_phys), .src2_phys(src2_phys), .old_phys(old_phys)
    );

    free_list free_i (
        .clock(clock), .reset(reset), .pop(dispatch_en),
        .push(retire_valid), .push_phys(retire_old_phys),   // old mapping goes back
        .head_phys(new_phys), .empty(fl_empty)
    );

    phys_regfile prf_i (
        .clock(clock), .reset(reset), .rd1_phys(src1_phys), .rd2_phys(src2_phys),
        .alloc_en(dispatch_en), .alloc_phys(new_phys),
        .wr_en(cdb_valid), .wr_phys(cdb_phys), .wr_data(cdb_data),
        .rd1_data(src1_data), .rd2_data(src2_data),
        .rd1_ready(src1_ready), .rd2_ready(src2_ready)
    );

    rs #(.rs_depth(rename_pkg::rs_depth)) rs_i (
        .clock(clock), .reset(reset), .dispatch_en(dispatch_en),
        .op(in_op), .imm(in_imm), .dest_phys(new_phys), .tag(alloc_tag),
        .src1_phys(src1_phys), .src2_phys(src2_phys),
        .src1_data(src1_data), .src2_data(src2_data),
        .src1_ready(src1_ready), .src2_ready(src2_ready),
        .cdb_valid(cdb_valid), .cdb_phys(cdb_phys), .cdb_data(cdb_data),
        .full(rs_full), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b), .issue_imm(issue_imm),
        .issue_dest_phys(issue_dest_phys), .issue_tag(issue_tag)
    );

    alu_fu alu_i (
        .clock(clock), .reset(reset), .issue_valid(issue_valid),
        .issue_op(issue_op), .issue_a(issue_a), .issue_b(issue_b),
        .issue_imm(issue_imm), .issue_dest_phys(issue_dest_phys),
        .issue_tag(issue_tag), .cdb_valid(cdb_valid), .cdb_phys(cdb_phys),
        .cdb_tag(cdb_tag), .cdb_data(cdb_data)
    );

    rob #(.rob_depth(rename_pkg::rob_depth)) rob_i (
        .clock(clock), .reset(reset), .dispatch_en(dispatch_en),
        .dest(in_dest), .old_phys(old_phys),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .alloc_tag(alloc_tag), .full(rob_full), .retire_valid(retire_valid),
        .retire_dest(commit_dest), .retire_data(commit_data),   // already registered
        .retire_old_phys(retire_old_phys)
    );

endmodule

// ==== cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

    localparam int half_period  = 4;
    localparam int reset_cycles = 4;
    localparam int num_tests    = 31;
    localparam int fields       = 6;    // op dest src1 src2 imm expected
    localparam int burst_first  = 13;   // first line of the back-to-back run
    localparam int cycle_limit  = 20 * num_tests + 100;

    logic                  clock;
    logic                  reset;
    logic                  in_valid;
    rename_pkg::alu_op_t   in_op;
    rename_pkg::arch_idx_t in_dest;
    rename_pkg::arch_idx_t in_src1;
    rename_pkg::arch_idx_t in_src2;
    rename_pkg::imm_t      in_imm;
    logic                  dispatch_open;
    logic                  commit_valid;
    rename_pkg::arch_idx_t commit_dest;
    rename_pkg::data_t     commit_data;

    logic [31:0] tests [num_tests * fields];
    logic [31:0] lfsr_state = 32'hd13b007a;

    int sent         = 0;
    int commits      = 0;
    int stall_cycles = 0;
    int cycle_count  = 0;

    cpu dut_i (
        .clock(clock), .reset(reset), .in_valid(in_valid), .in_op(in_op),
        .in_dest(in_dest), .in_src1(in_src1), .in_src2(in_src2), .in_imm(in_imm),
        .dispatch_open(dispatch_open), .commit_valid(commit_valid),
        .commit_dest(commit_dest), .commit_data(commit_data)
    );

    always #(half_period) clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value      = (value << 1) | {31'b0, lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic send_instr(input int idx);
        logic taken;
        in_valid = 1'b1;
        in_op    = rename_pkg::alu_op_t'(tests[idx * fields][2:0]);
        in_dest  = tests[idx * fields + 1][2:0];
        in_src1  = tests[idx * fields + 2][2:0];
        in_src2  = tests[idx * fields + 3][2:0];
        in_imm   = tests[idx * fields + 4][15:0];
        taken    = 1'b0;
        while (!taken) begin
            taken = dispatch_open;   // stable until the next edge
            if (!taken) begin
                stall_cycles++;
            end
            @(posedge clock);
            #1;
        end
        sent++;
        in_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // commit monitor and watchdog
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset && commit_valid) begin
            assert (commits < sent) else begin
                $display("commit pulse seen with no instruction outstanding");
                report_failure();
            end
            assert (commit_dest === tests[commits * fields + 1][2:0]) else begin
                $display("[FAIL] commit_dest: expected %h, got %h",
                         tests[commits * fields + 1][2:0], commit_dest);
                report_failure();
            end
            assert (commit_data === tests[commits * fields + 5]) else begin
                $display("[FAIL] commit_data: expected %h, got %h",
                         tests[commits * fields + 5], commit_data);
                report_failure();
            end
            commits++;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: only %0d of %0d instructions committed", commits, num_tests);
            report_failure();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int   gap;
        logic ok_end;
        clock    = 1'b0;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_op    = rename_pkg::op_add;
        in_dest  = '0;
        in_src1  = '0;
        in_src2  = '0;
        in_imm   = '0;
        $readmemh("cpu_tests.txt", tests);
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;

        // idle after reset, the monitor catches any stray commit
        repeat (3) begin
            @(posedge clock);
            #1;
            assert (dispatch_open === 1'b1) else begin
                $display("[FAIL] dispatch_open: expected 1, got %h", dispatch_open);
                report_failure();
            end
        end

        for (int i = 0; i < num_tests; i++) begin
            gap = 0;
            if (i < burst_first) begin
                draw_bits(2, gap);   // no gaps in the burst
            end
            repeat (gap) begin
                @(posedge clock);
                #1;
            end
            send_instr(i);
        end

        wait (commits == num_tests);
        repeat (5) @(posedge clock);   // room for an extra commit to show up

        ok_end = (stall_cycles > 0);
        assert (ok_end) else $display("dispatch_open never dropped during the run");
        if (ok_end) begin
            $display("No errors");
            $finish;
        end else begin
            report_failure();
        end
    end

endmodule

// ==== cpu_tests.txt ====
// columns: op dest src1 src2 imm expected, all hex
// op: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 li (sign-extended imm)
5 1 0 0 1234 00001234
5 2 0 0 ff00 ffffff00
0 3 1 2 0000 00001134
1 4 1 2 0000 00001334
2 5 1 2 0000 00001200
3 6 1 2 0000 ffffff34
4 7 1 2 0000 ffffed34
0 1 1 1 0000 00002468
1 1 1 3 0000 00001334
4 0 1 4 0000 00000000
5 0 0 0 8001 ffff8001
3 2 0 2 0000 ffffff01
2 3 2 7 0000 ffffed00
// back-to-back run
5 1 0 0 0007 00000007
0 1 1 1 0000 0000000e
0 1 1 1 0000 0000001c
1 2 1 4 0000 ffffece8
4 2 2 7 0000 000001dc
0 1 1 2 0000 000001f8
3 5 1 5 0000 000013f8
2 6 5 6 0000 00001330
1 6 6 4 0000 fffffffc
0 0 6 0 0000 ffff7ffd
4 3 3 0 0000 000092fd
5 7 0 0 7fff 00007fff
0 7 7 3 0000 000112fc
1 4 7 7 0000 00000000
3 4 4 1 0000 000001f8
0 2 2 4 0000 000003d4
4 5 5 2 0000 0000102c
2 1 5 7 0000 0000102c

// ==== list.f ====
rename_pkg.sv
map_table.sv
free_list.sv
phys_regfile.sv
rs.sv
alu_fu.sv
rob.sv
cpu.sv
cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
